/* lce_cluster.f */
logic/lce_cfg_pkg.sv
logic/lce_msg_pkg.sv
logic/lce_miss_handler.sv
logic/lce_cmd_decoder.sv
logic/lce_out_arbiter.sv
logic/lce_cluster.sv
test/lce_cluster_tb.sv

/* run_sim.sh */
#!/bin/sh
# build the testbench with Verilator, run it, and pass only if the pass message shows up
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module lce_cluster_tb \
  -f lce_cluster.f -o lce_cluster_sim || { echo "build failed"; exit 1; }
out=$(./obj_dir/lce_cluster_sim 2>&1)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx "No errors" && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

/* test/lce_cluster_tb.sv */
// random-stimulus testbench for lce_cluster that compares every response against a per-handler model
`timescale 1ns/1ps
`default_nettype none

module lce_cluster_tb;
  import lce_cfg_pkg::*;
  import lce_msg_pkg::*;

  localparam int total_misses_lp = 400;
  localparam int max_cycles_lp   = 60000;
  localparam int miss_timeout_lp = 400;

  typedef enum logic [1:0] {
    e_idle,
    e_req_wait,
    e_sleep,
    e_ack_wait
  } phase_e;

  logic                                       clk_i;
  logic                                       reset_i;
  logic [num_lce_lp-1:0]                      miss_v_i;
  miss_req_t [num_lce_lp-1:0]                 miss_req_i;
  logic [num_lce_lp-1:0]                      cache_miss_o;
  logic [num_lce_lp-1:0][paddr_width_lp-1:0]  miss_addr_o;
  logic                                       cmd_v_i;
  cce_cmd_t                                   cmd_i;
  logic                                       out_v_o;
  lce_msg_t                                   out_msg_o;
  logic                                       out_ready_i;

  // model of each handler
  phase_e    phase          [num_lce_lp];
  miss_req_t held           [num_lce_lp];
  ack_type_e ack_exp        [num_lce_lp];
  int        cmds_left      [num_lce_lp];
  int        last_cmd_cycle [num_lce_lp];
  int        valid_cycle    [num_lce_lp];
  int        waits          [num_lce_lp];
  int        age            [num_lce_lp];

  // outbound message refused in the previous cycle
  logic      stalled;
  lce_msg_t  stalled_msg;

  cce_cmd_t    cmd_q [$];
  logic [31:0] lcg_state;
  int          cycle;
  int          issued;
  int          completed;

  lce_cluster uut (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .miss_v_i     (miss_v_i),
    .miss_req_i   (miss_req_i),
    .cache_miss_o (cache_miss_o),
    .miss_addr_o  (miss_addr_o),
    .cmd_v_i      (cmd_v_i),
    .cmd_i        (cmd_i),
    .out_v_o      (out_v_o),
    .out_msg_o    (out_msg_o),
    .out_ready_i  (out_ready_i)
  );

  initial clk_i = 1'b0;
  always #4 clk_i = ~clk_i;

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  task automatic stop_with_error(input string line);
    $display("%s", line);
    $display("Errors found");
    $fatal(1);
  endtask

  task automatic check_msg(input string name, input lce_msg_t exp, input lce_msg_t act);
    if (act !== exp) begin
      stop_with_error($sformatf("Fail %s expected %h got %h", name, exp, act));
    end
  endtask

  task automatic check_addr(input string name, input logic [paddr_width_lp-1:0] exp,
                            input logic [paddr_width_lp-1:0] act);
    if (act !== exp) begin
      stop_with_error($sformatf("Fail %s expected %h got %h", name, exp, act));
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      stop_with_error($sformatf("Fail %s expected %h got %h", name, exp, act));
    end
  endtask

  function automatic miss_req_t random_miss();
    miss_req_t   q;
    logic [31:0] a;
    logic [31:0] b;
    a = lcg_next();
    b = lcg_next();
    q.kind    = miss_kind_e'(b[31:30]);
    q.addr    = a;
    q.lru_way = b[29:27];
    q.dirty   = b[26:19];
    q.size    = b[18:17];
    return q;
  endfunction

  // request built from the latched miss with lr sent as a write
  function automatic lce_msg_t expected_request(input int h);
    lce_msg_t  m;
    miss_req_t q;
    q = held[h];
    m = '0;
    m.is_resp                    = 1'b0;
    m.payload.req.src_lce        = lce_id_width_lp'(h);
    m.payload.req.dst_cce        = q.addr[block_offset_width_lp +: cce_id_width_lp];
    m.payload.req.write_not_read = (q.kind == e_miss_store) || (q.kind == e_miss_lr);
    m.payload.req.non_cacheable  = (q.kind == e_miss_uc_load);
    m.payload.req.size           = q.size;
    m.payload.req.lru_way        = q.lru_way;
    m.payload.req.lru_dirty      = q.dirty[q.lru_way];
    m.payload.req.addr           = q.addr;
    return m;
  endfunction

  function automatic lce_msg_t expected_ack(input int h);
    lce_msg_t m;
    m = '0;
    m.is_resp               = 1'b1;
    m.payload.resp.src_lce  = lce_id_width_lp'(h);
    m.payload.resp.dst_cce  = held[h].addr[block_offset_width_lp +: cce_id_width_lp];
    m.payload.resp.ack_type = ack_exp[h];
    m.payload.resp.addr     = held[h].addr;
    return m;
  endfunction

  function automatic logic has_valid_msg(input int h);
    return ((phase[h] == e_req_wait) || (phase[h] == e_ack_wait)) && (cycle >= valid_cycle[h]);
  endfunction

  // pick one of the resolving command sequences for handler h
  task automatic queue_resolution(input int h);
    logic [31:0] r;
    int          sel;
    cce_cmd_t    a;
    cce_cmd_t    b;
    r = lcg_next();
    sel = int'(r[31:16]) % 5;
    a.dst_lce = lce_id_width_lp'(h);
    b.dst_lce = lce_id_width_lp'(h);
    a.cmd_type = e_cmd_set_tag;
    b.cmd_type = e_cmd_data;
    ack_exp[h] = e_ack_coh;
    if (held[h].kind == e_miss_uc_load) begin
      a.cmd_type = e_cmd_uncached_data;
      cmd_q.push_back(a);
      cmds_left[h] = 1;
    end else if (sel == 0) begin
      a.cmd_type = e_cmd_set_tag_wakeup;
      cmd_q.push_back(a);
      cmds_left[h] = 1;
    end else begin
      if (sel > 2) begin
        b.cmd_type = e_cmd_transfer;
        ack_exp[h] = e_ack_tr;
      end
      // set-tag may come before or after the other command
      if (sel % 2 == 1) begin
        cmd_q.push_back(a);
        cmd_q.push_back(b);
      end else begin
        cmd_q.push_back(b);
        cmd_q.push_back(a);
      end
      cmds_left[h] = 2;
    end
  endtask

  task automatic drive_inputs();
    logic [31:0] r;
    cce_cmd_t    c;
    cycle++;
    for (int h = 0; h < num_lce_lp; h++) begin
      r = lcg_next();
      if (phase[h] == e_idle) begin
        miss_req_i[h] = random_miss();
        miss_v_i[h] = (issued < total_misses_lp) && (r[31:30] == 2'b00);
        if (miss_v_i[h]) begin
          issued++;
        end
      end else begin
        // busy handler ignores miss_v_i while its request is held steady
        miss_v_i[h] = r[29];
      end
    end
    r = lcg_next();
    out_ready_i = (r[27:26] != 2'b00);
    if ((cmd_q.size() > 0) && (r[31:30] != 2'b00)) begin
      c = cmd_q.pop_front();
      cmd_v_i = 1'b1;
      cmd_i = c;
      cmds_left[c.dst_lce]--;
      if (cmds_left[c.dst_lce] == 0) begin
        last_cmd_cycle[c.dst_lce] = cycle;
      end
    end else begin
      cmd_v_i = 1'b0;
      cmd_i = cce_cmd_t'(r[4:0]);
    end
  endtask

  task automatic check_cycle();
    int                    h;
    logic                  any_valid;
    logic [num_lce_lp-1:0] accepted;
    any_valid = 1'b0;
    for (int k = 0; k < num_lce_lp; k++) begin
      accepted[k] = (phase[k] == e_idle) && miss_v_i[k];
      check_flag($sformatf("cache_miss_o[%0d]", k), (phase[k] != e_idle) || miss_v_i[k],
                 cache_miss_o[k]);
      check_addr($sformatf("miss_addr_o[%0d]", k),
                 (phase[k] == e_idle) ? miss_req_i[k].addr : held[k].addr, miss_addr_o[k]);
      if (has_valid_msg(k)) begin
        any_valid = 1'b1;
      end
      if (phase[k] != e_idle) begin
        age[k]++;
        if (age[k] > miss_timeout_lp) begin
          stop_with_error($sformatf("handler %0d did not finish its miss in time", k));
        end
      end
    end
    check_flag("out_v_o", any_valid, out_v_o);
    // a refused message comes back unchanged
    if (stalled) begin
      check_msg("out_msg_o", stalled_msg, out_msg_o);
    end
    stalled     = out_v_o && !out_ready_i;
    stalled_msg = out_msg_o;
    if (out_v_o) begin
      h = int'(out_msg_o.payload.req.src_lce);
      if (!has_valid_msg(h)) begin
        stop_with_error($sformatf("handler %0d sent a message it did not owe", h));
      end
      check_msg("out_msg_o", (phase[h] == e_req_wait) ? expected_request(h) : expected_ack(h),
                out_msg_o);
      if (out_ready_i) begin
        for (int k = 0; k < num_lce_lp; k++) begin
          if ((k != h) && has_valid_msg(k)) begin
            waits[k]++;
            if (waits[k] > num_lce_lp - 1) begin
              stop_with_error($sformatf("handler %0d was passed over by the arbiter", k));
            end
          end
        end
        waits[h] = 0;
        if (phase[h] == e_req_wait) begin
          phase[h] = e_sleep;
          queue_resolution(h);
        end else begin
          phase[h] = e_idle;
          completed++;
        end
      end
    end
    for (int k = 0; k < num_lce_lp; k++) begin
      // the last command reaches the handler one cycle after it was driven
      if ((phase[k] == e_sleep) && (cmds_left[k] == 0) && (cycle == last_cmd_cycle[k] + 1)) begin
        if (held[k].kind == e_miss_uc_load) begin
          phase[k] = e_idle;
          completed++;
        end else begin
          phase[k] = e_ack_wait;
          valid_cycle[k] = cycle + 1;
          waits[k] = 0;
        end
      end else if (accepted[k]) begin
        held[k] = miss_req_i[k];
        phase[k] = e_req_wait;
        valid_cycle[k] = cycle + 1;
        waits[k] = 0;
        age[k] = 0;
      end
    end
  endtask

  initial begin
    lcg_state   = 32'hac54_2009;
    reset_i     = 1'b1;
    miss_v_i    = '0;
    miss_req_i  = '0;
    cmd_v_i     = 1'b0;
    cmd_i       = '0;
    out_ready_i = 1'b0;
    cycle       = 0;
    issued      = 0;
    completed   = 0;
    stalled     = 1'b0;
    stalled_msg = '0;
    for (int k = 0; k < num_lce_lp; k++) begin
      phase[k]          = e_idle;
      held[k]           = '0;
      ack_exp[k]        = e_ack_coh;
      cmds_left[k]      = 0;
      last_cmd_cycle[k] = 0;
      valid_cycle[k]    = 0;
      waits[k]          = 0;
      age[k]            = 0;
    end
    repeat (8) @(posedge clk_i);
    #1 reset_i = 1'b0;
    while ((completed < total_misses_lp) && (cycle < max_cycles_lp)) begin
      @(posedge clk_i);
      #1;
      drive_inputs();
      @(negedge clk_i);
      check_cycle();
    end
    if (completed == total_misses_lp) begin
      $display("No errors");
      $finish;
    end else begin
      stop_with_error("timeout: the misses did not all complete within the cycle budget");
    end
  end

endmodule

`default_nettype wire

/* logic/lce_cluster.sv */
// top of the LCE request cluster: command decoder, one miss handler per cache, output arbiter
`timescale 1ns/1ps
`default_nettype none

module lce_cluster (
  input  logic                                                               clk_i,
  input  logic                                                               reset_i,
  input  logic [lce_cfg_pkg::num_lce_lp-1:0]                                 miss_v_i,
  input  lce_msg_pkg::miss_req_t [lce_cfg_pkg::num_lce_lp-1:0]               miss_req_i,
  output logic [lce_cfg_pkg::num_lce_lp-1:0]                                 cache_miss_o,
  output logic [lce_cfg_pkg::num_lce_lp-1:0][lce_cfg_pkg::paddr_width_lp-1:0] miss_addr_o,
  input  logic                                                               cmd_v_i,
  input  lce_msg_pkg::cce_cmd_t                                              cmd_i,
  output logic                                                               out_v_o,
  output lce_msg_pkg::lce_msg_t                                              out_msg_o,
  input  logic                                                               out_ready_i
);
  import lce_cfg_pkg::*;
  import lce_msg_pkg::*;

  lce_event_t [num_lce_lp-1:0] events;
  logic       [num_lce_lp-1:0] msg_v;
  lce_msg_t   [num_lce_lp-1:0] msg;
  logic       [num_lce_lp-1:0] msg_yumi;

  lce_cmd_decoder u_decoder (
    .clk_i    (clk_i),
    .reset_i  (reset_i),
    .cmd_v_i  (cmd_v_i),
    .cmd_i    (cmd_i),
    .events_o (events)
  );

  for (genvar i = 0; i < num_lce_lp; i++) begin : g_lce
    lce_miss_handler u_handler (
      .clk_i        (clk_i),
      .reset_i      (reset_i),
      .lce_id_i     (lce_id_width_lp'(i)),
      .miss_v_i     (miss_v_i[i]),
      .miss_req_i   (miss_req_i[i]),
      .event_i      (events[i]),
      .cache_miss_o (cache_miss_o[i]),
      .miss_addr_o  (miss_addr_o[i]),
      .msg_v_o      (msg_v[i]),
      .msg_o        (msg[i]),
      .msg_yumi_i   (msg_yumi[i])
    );
  end

  lce_out_arbiter u_arbiter (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .msg_v_i     (msg_v),
    .msg_i       (msg),
    .msg_yumi_o  (msg_yumi),
    .out_v_o     (out_v_o),
    .out_msg_o   (out_msg_o),
    .out_ready_i (out_ready_i)
  );

endmodule

`default_nettype wire

/* logic/lce_out_arbiter.sv */
// round-robin merge of handler messages onto the single outbound valid/ready channel
`timescale 1ns/1ps
`default_nettype none

module lce_out_arbiter (
  input  logic                                                clk_i,
  input  logic                                                reset_i,
  input  logic [lce_cfg_pkg::num_lce_lp-1:0]                  msg_v_i,
  input  lce_msg_pkg::lce_msg_t [lce_cfg_pkg::num_lce_lp-1:0] msg_i,
  output logic [lce_cfg_pkg::num_lce_lp-1:0]                  msg_yumi_o,
  output logic                                                out_v_o,
  output lce_msg_pkg::lce_msg_t                               out_msg_o,
  input  logic                                                out_ready_i
);
  import lce_cfg_pkg::*;

  logic [lce_id_width_lp-1:0] last_r;
  logic                       locked_r;
  logic [lce_id_width_lp-1:0] locked_id_r;
  logic                       grant_v;
  logic [lce_id_width_lp-1:0] grant_id;
  logic [lce_id_width_lp-1:0] cand;
  logic                       xfer;

  // search starts just after the last winner and wraps around
  always_comb begin
    grant_v  = 1'b0;
    grant_id = last_r;
    cand     = last_r;
    if (locked_r) begin
      // a stalled offer keeps its slot so out_msg_o does not change
      grant_v  = msg_v_i[locked_id_r];
      grant_id = locked_id_r;
    end else begin
      for (int i = 1; i <= num_lce_lp; i++) begin
        cand = last_r + lce_id_width_lp'(i);
        if (!grant_v && msg_v_i[cand]) begin
          grant_v  = 1'b1;
          grant_id = cand;
        end
      end
    end
  end

  assign xfer      = grant_v & out_ready_i;
  assign out_v_o   = grant_v;
  assign out_msg_o = msg_i[grant_id];

  always_comb begin
    msg_yumi_o = '0;
    msg_yumi_o[grant_id] = xfer;
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      // handler 0 gets first pick after reset
      last_r   <= lce_id_width_lp'(num_lce_lp - 1);
      locked_r <= 1'b0;
    end else begin
      if (xfer) begin
        last_r <= grant_id;
      end
      locked_r <= grant_v & ~out_ready_i;
    end
  end

  always_ff @(posedge clk_i) begin
    locked_id_r <= grant_id;
  end

  a_yumi_onehot0: assert property (@(posedge clk_i) disable iff (reset_i)
    $onehot0(msg_yumi_o));

  // a refused message stays on the channel unchanged
  a_out_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    (out_v_o && !out_ready_i) |=> (out_v_o && $stable(out_msg_o)));

endmodule

`default_nettype wire

/* logic/lce_cmd_decoder.sv */
// registers each directory command and delivers it as one event flag to the named handler
`timescale 1ns/1ps
`default_nettype none

module lce_cmd_decoder (
  input  logic                                                  clk_i,
  input  logic                                                  reset_i,
  input  logic                                                  cmd_v_i,
  input  lce_msg_pkg::cce_cmd_t                                 cmd_i,
  output lce_msg_pkg::lce_event_t [lce_cfg_pkg::num_lce_lp-1:0] events_o
);
  import lce_msg_pkg::*;

  logic       cmd_v_r;
  cce_cmd_t   cmd_r;
  lce_event_t event_flags;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      cmd_v_r <= 1'b0;
    end else begin
      cmd_v_r <= cmd_v_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (cmd_v_i) begin
      cmd_r <= cmd_i;
    end
  end

  // one flag per command kind
  always_comb begin
    event_flags = '0;
    case (cmd_r.cmd_type)
      e_cmd_set_tag:        event_flags.set_tag        = cmd_v_r;
      e_cmd_set_tag_wakeup: event_flags.set_tag_wakeup = cmd_v_r;
      e_cmd_data:           event_flags.data           = cmd_v_r;
      e_cmd_transfer:       event_flags.transfer       = cmd_v_r;
      e_cmd_uncached_data:  event_flags.uncached_data  = cmd_v_r;
      default:              event_flags                = '0;
    endcase
  end

  // only the addressed handler sees it
  always_comb begin
    events_o = '0;
    events_o[cmd_r.dst_lce] = event_flags;
  end

  a_events_onehot0: assert property (@(posedge clk_i) disable iff (reset_i)
    $onehot0(events_o));

  // every accepted command turns into exactly one event a cycle later
  a_cmd_to_event: assert property (@(posedge clk_i) disable iff (reset_i)
    cmd_v_i |=> $onehot(events_o));

endmodule

`default_nettype wire

/* logic/lce_miss_handler.sv */
// per-cache miss FSM: latches a miss, requests it from the directory, acks the resolution
`timescale 1ns/1ps
`default_nettype none

module lce_miss_handler (
  input  logic                                    clk_i,
  input  logic                                    reset_i,
  input  logic [lce_cfg_pkg::lce_id_width_lp-1:0] lce_id_i,
  input  logic                                    miss_v_i,
  input  lce_msg_pkg::miss_req_t                  miss_req_i,
  input  lce_msg_pkg::lce_event_t                 event_i,
  output logic                                    cache_miss_o,
  output logic [lce_cfg_pkg::paddr_width_lp-1:0]  miss_addr_o,
  output logic                                    msg_v_o,
  output lce_msg_pkg::lce_msg_t                   msg_o,
  input  logic                                    msg_yumi_i
);
  import lce_cfg_pkg::*;
  import lce_msg_pkg::*;

  typedef enum logic [2:0] {
    e_ready,
    e_send_req,
    e_sleep,
    e_send_tr_ack,
    e_send_coh_ack
  } state_e;

  state_e                     state_r;
  state_e                     state_n;
  miss_kind_e                 kind_r;
  logic [paddr_width_lp-1:0]  addr_r;
  logic [size_width_lp-1:0]   size_r;
  logic [way_id_width_lp-1:0] lru_way_r;
  logic                       lru_dirty_r;
  logic                       lru_taken_r;
  logic                       set_tag_r;
  logic                       data_r;
  logic                       transfer_r;
  logic                       set_tag_seen;
  logic                       data_seen;
  logic                       transfer_seen;
  logic                       accept;
  logic [way_id_width_lp-1:0] lru_way;
  logic                       lru_dirty;
  logic [cce_id_width_lp-1:0] dst_cce;

  assign accept = (state_r == e_ready) & miss_v_i;

  // flags seen so far, including this cycle's pulse
  assign set_tag_seen  = set_tag_r | event_i.set_tag;
  assign data_seen     = data_r | event_i.data;
  assign transfer_seen = transfer_r | event_i.transfer;

  // live LRU on the first request cycle, frozen afterwards
  assign lru_way   = lru_taken_r ? lru_way_r : miss_req_i.lru_way;
  assign lru_dirty = lru_taken_r ? lru_dirty_r : miss_req_i.dirty[miss_req_i.lru_way];

  // directory slice is picked by the bits above the block offset
  assign dst_cce = addr_r[block_offset_width_lp +: cce_id_width_lp];

  assign cache_miss_o = (state_r != e_ready) | accept;
  assign miss_addr_o  = (state_r == e_ready) ? miss_req_i.addr : addr_r;

  always_comb begin
    state_n = state_r;
    unique case (state_r)
      e_ready: begin
        if (miss_v_i) begin
          state_n = e_send_req;
        end
      end
      e_send_req: begin
        if (msg_yumi_i) begin
          state_n = e_sleep;
        end
      end
      e_sleep: begin
        if (event_i.set_tag_wakeup) begin
          state_n = e_send_coh_ack;
        end else if (event_i.uncached_data) begin
          state_n = e_ready;
        end else if (set_tag_seen && transfer_seen) begin
          state_n = e_send_tr_ack;
        end else if (set_tag_seen && data_seen) begin
          state_n = e_send_coh_ack;
        end
      end
      e_send_tr_ack, e_send_coh_ack: begin
        if (msg_yumi_i) begin
          state_n = e_ready;
        end
      end
      default: begin
        state_n = e_ready;
      end
    endcase
  end

  assign msg_v_o = (state_r == e_send_req) | (state_r == e_send_tr_ack)
                 | (state_r == e_send_coh_ack);

  always_comb begin
    msg_o = '0;
    if (state_r == e_send_req) begin
      msg_o.is_resp                    = 1'b0;
      msg_o.payload.req.src_lce        = lce_id_i;
      msg_o.payload.req.dst_cce        = dst_cce;
      // lr asks for a write to get the block exclusive
      msg_o.payload.req.write_not_read = (kind_r == e_miss_store) | (kind_r == e_miss_lr);
      msg_o.payload.req.non_cacheable  = (kind_r == e_miss_uc_load);
      msg_o.payload.req.size           = size_r;
      msg_o.payload.req.lru_way        = lru_way;
      msg_o.payload.req.lru_dirty      = lru_dirty;
      msg_o.payload.req.addr           = addr_r;
    end else begin
      msg_o.is_resp               = 1'b1;
      msg_o.payload.resp.src_lce  = lce_id_i;
      msg_o.payload.resp.dst_cce  = dst_cce;
      msg_o.payload.resp.ack_type = (state_r == e_send_tr_ack) ? e_ack_tr : e_ack_coh;
      msg_o.payload.resp.addr     = addr_r;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r     <= e_ready;
      lru_taken_r <= 1'b0;
      set_tag_r   <= 1'b0;
      data_r      <= 1'b0;
      transfer_r  <= 1'b0;
    end else begin
      state_r <= state_n;
      if (accept) begin
        lru_taken_r <= 1'b0;
        set_tag_r   <= 1'b0;
        data_r      <= 1'b0;
        transfer_r  <= 1'b0;
      end else if (state_r != e_ready) begin
        set_tag_r  <= set_tag_seen;
        data_r     <= data_seen;
        transfer_r <= transfer_seen;
        if (state_r == e_send_req) begin
          lru_taken_r <= 1'b1;
        end
      end
    end
  end

  // latched miss
  always_ff @(posedge clk_i) begin
    if (accept) begin
      kind_r <= miss_req_i.kind;
      addr_r <= miss_req_i.addr;
      size_r <= miss_req_i.size;
    end
    if ((state_r == e_send_req) && !lru_taken_r) begin
      lru_way_r   <= lru_way;
      lru_dirty_r <= lru_dirty;
    end
  end

  // the decoder only targets a handler that has a miss outstanding
  a_no_event_when_ready: assert property (@(posedge clk_i) disable iff (reset_i)
    (state_r == e_ready) |-> (event_i == '0));

  // an offered message holds until the arbiter takes it
  a_msg_stable: assert property (@(posedge clk_i) disable iff (reset_i)
    (msg_v_o && !msg_yumi_i) |=> (msg_v_o && $stable(msg_o)));

endmodule

`default_nettype wire

/* logic/lce_msg_pkg.sv */
// message and command formats passed between the decoder, miss handlers and arbiter
`default_nettype none

package lce_msg_pkg;
  import lce_cfg_pkg::*;

  localparam int size_width_lp = 2;

  // request bits that a response leaves unused: non_cacheable, size, lru_way, lru_dirty
  localparam int resp_pad_width_lp = 1 + size_width_lp + way_id_width_lp + 1;

  typedef enum logic [1:0] {
    e_miss_load,
    e_miss_store,
    e_miss_lr,
    e_miss_uc_load
  } miss_kind_e;

  // miss as presented by the cache pipeline
  typedef struct packed {
    miss_kind_e                 kind;
    logic [paddr_width_lp-1:0]  addr;
    logic [way_id_width_lp-1:0] lru_way;
    logic [ways_lp-1:0]         dirty;
    logic [size_width_lp-1:0]   size;
  } miss_req_t;

  typedef enum logic [2:0] {
    e_cmd_set_tag,
    e_cmd_set_tag_wakeup,
    e_cmd_data,
    e_cmd_transfer,
    e_cmd_uncached_data
  } cmd_type_e;

  typedef struct packed {
    logic [lce_id_width_lp-1:0] dst_lce;
    cmd_type_e                  cmd_type;
  } cce_cmd_t;

  // one pulse per command kind, seen only by the addressed handler
  typedef struct packed {
    logic set_tag;
    logic set_tag_wakeup;
    logic data;
    logic transfer;
    logic uncached_data;
  } lce_event_t;

  typedef enum logic {
    e_ack_coh,
    e_ack_tr
  } ack_type_e;

  typedef struct packed {
    logic [lce_id_width_lp-1:0] src_lce;
    logic [cce_id_width_lp-1:0] dst_cce;
    logic                       write_not_read;
    logic                       non_cacheable;
    logic [size_width_lp-1:0]   size;
    logic [way_id_width_lp-1:0] lru_way;
    logic                       lru_dirty;
    logic [paddr_width_lp-1:0]  addr;
  } req_msg_t;

  // ack_type sits where write_not_read sits, addr stays aligned
  typedef struct packed {
    logic [lce_id_width_lp-1:0]   src_lce;
    logic [cce_id_width_lp-1:0]   dst_cce;
    ack_type_e                    ack_type;
    logic [resp_pad_width_lp-1:0] pad;
    logic [paddr_width_lp-1:0]    addr;
  } resp_msg_t;

  typedef union packed {
    req_msg_t  req;
    resp_msg_t resp;
  } lce_msg_u;

  // is_resp picks the view of payload
  typedef struct packed {
    logic     is_resp;
    lce_msg_u payload;
  } lce_msg_t;

endpackage

`default_nettype wire

/* logic/lce_cfg_pkg.sv */
// cluster sizing constants, imported by the LCE request RTL and its testbench
`default_nettype none

package lce_cfg_pkg;

  // handlers in the cluster and directory slices behind them
  localparam int num_lce_lp = 4;
  localparam int num_cce_lp = 2;

  // physical address and cache geometry
  localparam int paddr_width_lp = 32;
  localparam int ways_lp = 8;

  // 64-byte blocks
  localparam int block_offset_width_lp = 6;

  // id widths follow from the counts above
  localparam int lce_id_width_lp = $clog2(num_lce_lp);
  localparam int cce_id_width_lp = $clog2(num_cce_lp);
  localparam int way_id_width_lp = $clog2(ways_lp);

endpackage

`default_nettype wire
